// File: project.f
+incdir+hdl
hdl/daddaPkg.sv
hdl/partialProductGen.sv
hdl/daddaReduceStage.sv
hdl/daddaReduceTree.sv
hdl/carryPropagateAdder.sv
hdl/daddaMultiplier.sv
tests/daddaMultiplierTb.sv

// File: Bender.yml
package:
  name: dadda_multiplier

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/daddaPkg.sv
      - hdl/partialProductGen.sv
      - hdl/daddaReduceStage.sv
      - hdl/daddaReduceTree.sv
      - hdl/carryPropagateAdder.sv
      - hdl/daddaMultiplier.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/daddaMultiplierTb.sv

// File: tests/daddaMultiplierTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dadda_defines.svh"

module daddaMultiplierTb
  import daddaPkg::*;
();

  localparam int LAT = `PIPE_LATENCY;

  logic    clk;
  logic    arstN;
  logic    inValid;
  mulReqT  operands;
  logic    outValid;
  productT product;

  // Reference model of the valid pipeline and the expected products
  logic [LAT-1:0] validPipe;
  productT        expQueue [$];
  productT        expProduct;
  int             outCount = 0;

  daddaMultiplier daddaMultiplier_inst (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .operands(operands),
    .outValid(outValid),
    .product (product)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopRun();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic reportMismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stopRun();
  endtask

  // Expected product is the full-width a times b
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validPipe <= '0;
      expProduct <= '0;
      expQueue.delete();
    end else begin
      validPipe <= {validPipe[LAT-2:0], inValid};
      // Result register loads as the request enters the last slice
      if (validPipe[LAT-2]) begin
        expProduct <= expQueue.pop_front();
      end
      if (inValid) begin
        expQueue.push_back(productT'(operands.a) * productT'(operands.b));
      end
    end
  end

  // Results counted on the falling edge
  always @(negedge clk) begin
    if (arstN && outValid) begin
      outCount <= outCount + 1;
    end
  end

  validTiming: assert property (@(posedge clk) outValid == validPipe[LAT-1])
    else reportMismatch($sformatf("outValid is %0b, expected %0b",
                                  $sampled(outValid), $sampled(validPipe[LAT-1])));

  productValue: assert property (@(posedge clk) product == expProduct)
    else reportMismatch($sformatf("product is 0x%08h, expected 0x%08h",
                                  $sampled(product), $sampled(expProduct)));

  resetOutputs: assert property (@(posedge clk) !arstN |-> (!outValid && product == '0))
    else reportMismatch("outputs are not cleared while reset is held");

  task automatic driveCycle(input logic valid, input operandT a, input operandT b);
    @(posedge clk);
    #2;
    inValid = valid;
    operands.a = a;
    operands.b = b;
  endtask

  task automatic sendPair(input operandT a, input operandT b);
    driveCycle(1'b1, a, b);
  endtask

  // Idle cycles drive random operands with inValid low
  task automatic idleCycles(input int n);
    for (int k = 0; k < n; k++) begin
      driveCycle(1'b0, operandT'($urandom), operandT'($urandom));
    end
  endtask

  task automatic drainPipe();
    int cycles;
    cycles = 0;
    idleCycles(1);
    while (validPipe != '0 && cycles <= 4 * LAT) begin
      idleCycles(1);
      cycles++;
    end
    if (validPipe != '0) begin
      $display("Timeout: pipeline did not drain within %0d cycles", 4 * LAT);
      stopRun();
    end
  endtask

  initial begin
    #1_000_000;
    $display("Timeout: simulation ran past its time limit");
    stopRun();
  end

  initial begin
    int      burstStart;
    operandT a;
    void'($urandom(90));
    arstN = 1'b1;
    inValid = 1'b0;
    operands = '0;
    #1;
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    arstN = 1'b1;
    // Quiet cycles after reset release
    idleCycles(4);

    for (int n = 0; n < 300; n++) begin
      sendPair(operandT'($urandom), operandT'($urandom));
      idleCycles($urandom % 4);
    end
    drainPipe();

    // Corner operands sent back to back
    for (int n = 0; n < 8; n++) begin
      a = operandT'($urandom);
      sendPair('0, a);
      sendPair(a, '0);
      sendPair(16'd1, a);
      sendPair(a, 16'd1);
    end
    sendPair('1, '1);
    sendPair(16'hAAAA, 16'h5555);
    sendPair(16'h5555, 16'hAAAA);
    sendPair(16'hAAAA, 16'hAAAA);
    sendPair(16'h5555, 16'h5555);
    for (int i = 0; i < `OPERAND_WIDTH; i++) begin
      sendPair(operandT'(1) << i, '1);
      sendPair('1, operandT'(1) << i);
      for (int j = 0; j < `OPERAND_WIDTH; j++) begin
        sendPair(operandT'(1) << i, operandT'(1) << j);
      end
    end
    drainPipe();

    // Fifty back-to-back requests
    burstStart = outCount;
    for (int n = 0; n < 50; n++) begin
      sendPair(operandT'($urandom), operandT'($urandom));
    end
    drainPipe();
    burstCount: assert (outCount - burstStart == 50)
      else reportMismatch($sformatf("burst gave %0d results, expected 50",
                                    outCount - burstStart));

    // Reset while three requests are in flight
    sendPair(operandT'($urandom), operandT'($urandom));
    sendPair(operandT'($urandom), operandT'($urandom));
    sendPair(operandT'($urandom), operandT'($urandom));
    @(posedge clk);
    #2;
    inValid = 1'b0;
    arstN = 1'b0;
    #1;
    resetAtOnce: assert (!outValid && product == '0)
      else reportMismatch("reset did not clear the outputs at once");
    repeat (5) @(posedge clk);
    #2;
    arstN = 1'b1;
    idleCycles(6);

    for (int n = 0; n < 20; n++) begin
      sendPair(operandT'($urandom), operandT'($urandom));
      idleCycles($urandom % 2);
    end
    drainPipe();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/daddaMultiplier.sv
`timescale 1ns/100ps
`default_nettype none

module daddaMultiplier
  import daddaPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    inValid,
  input  mulReqT  operands,
  output logic    outValid,
  output productT product
);

  logic      matrixValid;
  dotMatrixT matrix;
  logic      rowsValid;
  twoRowT    rows;

  // Decode
  partialProductGen partialProductGen_inst (
    .clk        (clk),
    .arstN      (arstN),
    .inValid    (inValid),
    .operands   (operands),
    .matrixValid(matrixValid),
    .matrix     (matrix)
  );

  // Execute
  daddaReduceTree daddaReduceTree_inst (
    .clk        (clk),
    .arstN      (arstN),
    .matrixValid(matrixValid),
    .matrix     (matrix),
    .rowsValid  (rowsValid),
    .rows       (rows)
  );

  // Result
  carryPropagateAdder carryPropagateAdder_inst (
    .clk      (clk),
    .arstN    (arstN),
    .rowsValid(rowsValid),
    .rows     (rows),
    .outValid (outValid),
    .product  (product)
  );

endmodule

`default_nettype wire

// File: hdl/carryPropagateAdder.sv
`timescale 1ns/100ps
`default_nettype none

`include "dadda_defines.svh"

module carryPropagateAdder
  import daddaPkg::*;
(
  input  logic    clk,
  input  logic    arstN,
  input  logic    rowsValid,
  input  twoRowT  rows,
  output logic    outValid,
  output productT product
);

  productT sum;

  // Ripple chain, carry out of the top bit cannot be set for a 16x16 product
  always_comb begin
    logic      carry;
    addResultT bitRes;
    carry = 1'b0;
    bitRes = '0;
    sum = '0;
    for (int i = 0; i < `PRODUCT_WIDTH; i++) begin
      bitRes = fullAdd(rows.rowA[i], rows.rowB[i], carry);
      sum[i] = bitRes.sum;
      carry = bitRes.carry;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= rowsValid;
    end
  end

  // Product holds its last value between results
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      product <= '0;
    end else if (rowsValid) begin
      product <= sum;
    end
  end

endmodule

`default_nettype wire

// File: hdl/daddaReduceTree.sv
`timescale 1ns/100ps
`default_nettype none

`include "dadda_defines.svh"

module daddaReduceTree
  import daddaPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      matrixValid,
  input  dotMatrixT matrix,
  output logic      rowsValid,
  output twoRowT    rows
);

  // Entry k feeds stage k, the last entry holds at most two dots per column
  dotMatrixT stageMatrix [`REDUCE_STAGES + 1];
  twoRowT    nextRows;

  assign stageMatrix[0] = matrix;

  // Heights fall 13, 9, 6, 4, 3, 2
  for (genvar s = 0; s < `REDUCE_STAGES; s++) begin : genStage
    daddaReduceStage #(
      .STAGE_INDEX(s)
    ) daddaReduceStage_inst (
      .inMatrix (stageMatrix[s]),
      .outMatrix(stageMatrix[s + 1])
    );
  end

  always_comb begin
    nextRows = '0;
    for (int c = 0; c < `PRODUCT_WIDTH; c++) begin
      nextRows.rowA[c] = stageMatrix[`REDUCE_STAGES][c][0];
      nextRows.rowB[c] = stageMatrix[`REDUCE_STAGES][c][1];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rowsValid <= 1'b0;
    end else begin
      rowsValid <= matrixValid;
    end
  end

  always_ff @(posedge clk) begin
    if (matrixValid) begin
      rows <= nextRows;
    end
  end

endmodule

`default_nettype wire

// File: hdl/daddaReduceStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "dadda_defines.svh"

module daddaReduceStage
  import daddaPkg::*;
#(
  parameter int STAGE_INDEX = 0
) (
  input  dotMatrixT inMatrix,
  output dotMatrixT outMatrix
);

  localparam int TARGET = daddaTarget(STAGE_INDEX);

  // Number of adders placed in a column, which is also its carry count
  function automatic int adderCount(input int col);
    int carry;
    int eff;
    int excess;
    carry = 0;
    for (int k = 0; k <= col; k++) begin
      eff = columnHeight(STAGE_INDEX, k) + carry;
      excess = (eff > TARGET) ? eff - TARGET : 0;
      carry = excess / 2 + excess % 2;
    end
    return carry;
  endfunction

  // Carries leaving each column, low positions first
  dotMatrixT carryMatrix;

  for (genvar c = 0; c < `PRODUCT_WIDTH; c++) begin : genColumn
    localparam int HEIGHT = columnHeight(STAGE_INDEX, c);
    localparam int CARRY_IN = (c == 0) ? 0 : adderCount(c - 1);
    localparam int EFFECTIVE = HEIGHT + CARRY_IN;
    localparam int EXCESS = (EFFECTIVE > TARGET) ? EFFECTIVE - TARGET : 0;
    localparam int FULL_COUNT = EXCESS / 2;
    localparam int HALF_COUNT = EXCESS % 2;
    localparam int ADDERS = FULL_COUNT + HALF_COUNT;
    // Dots taken from the bottom of the column by the adders
    localparam int USED = 3 * FULL_COUNT + 2 * HALF_COUNT;

    columnT carryIn;
    columnT colOut;
    columnT carryOut;

    if (c == 0) begin : genNoCarry
      assign carryIn = '0;
    end else begin : genCarry
      assign carryIn = carryMatrix[c - 1];
    end

    always_comb begin
      addResultT fullRes;
      addResultT halfRes;
      fullRes = '0;
      halfRes = '0;
      colOut = '0;
      carryOut = '0;

      // Incoming carries at the bottom
      for (int k = 0; k < CARRY_IN; k++) begin
        colOut[k] = carryIn[k];
      end

      for (int k = 0; k < FULL_COUNT; k++) begin
        fullRes = fullAdd(inMatrix[c][3 * k], inMatrix[c][3 * k + 1],
                          inMatrix[c][3 * k + 2]);
        colOut[CARRY_IN + k] = fullRes.sum;
        carryOut[k] = fullRes.carry;
      end

      // At most one half adder per column
      for (int k = 0; k < HALF_COUNT; k++) begin
        halfRes = halfAdd(inMatrix[c][3 * FULL_COUNT + 2 * k],
                          inMatrix[c][3 * FULL_COUNT + 2 * k + 1]);
        colOut[CARRY_IN + FULL_COUNT + k] = halfRes.sum;
        carryOut[FULL_COUNT + k] = halfRes.carry;
      end

      // Untouched dots pack above the sums
      for (int k = 0; k < HEIGHT - USED; k++) begin
        colOut[CARRY_IN + ADDERS + k] = inMatrix[c][USED + k];
      end
    end

    assign outMatrix[c] = colOut;
    assign carryMatrix[c] = carryOut;
  end

endmodule

`default_nettype wire

// File: hdl/partialProductGen.sv
`timescale 1ns/100ps
`default_nettype none

`include "dadda_defines.svh"

module partialProductGen
  import daddaPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      inValid,
  input  mulReqT    operands,
  output logic      matrixValid,
  output dotMatrixT matrix
);

  dotMatrixT nextMatrix;

  // AND array, bit i of a times bit j of b lands in column i+j
  always_comb begin
    int pos;
    nextMatrix = '0;
    for (int i = 0; i < `OPERAND_WIDTH; i++) begin
      for (int j = 0; j < `OPERAND_WIDTH; j++) begin
        // Lowest i in the column takes position 0
        if (i + j < `OPERAND_WIDTH) begin
          pos = i;
        end else begin
          pos = `OPERAND_WIDTH - 1 - j;
        end
        nextMatrix[i + j][pos] = operands.a[i] & operands.b[j];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      matrixValid <= 1'b0;
    end else begin
      matrixValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      matrix <= nextMatrix;
    end
  end

endmodule

`default_nettype wire

// File: hdl/daddaPkg.sv
`default_nettype none

`include "dadda_defines.svh"

package daddaPkg;

  typedef logic [`OPERAND_WIDTH-1:0] operandT;
  typedef logic [`PRODUCT_WIDTH-1:0] productT;

  typedef struct packed {
    operandT a;
    operandT b;
  } mulReqT;

  // Dots packed from index 0 upward, unused positions are zero
  typedef logic [`MAX_HEIGHT-1:0] columnT;
  typedef columnT [`PRODUCT_WIDTH-1:0] dotMatrixT;

  typedef struct packed {
    productT rowA;
    productT rowB;
  } twoRowT;

  typedef struct packed {
    logic sum;
    logic carry;
  } addResultT;

  // Stage 0 targets 13, the last stage targets 2
  function automatic int daddaTarget(input int stageIndex);
    int target;
    target = 2;
    for (int k = 0; k < `REDUCE_STAGES - 1 - stageIndex; k++) begin
      target = (target * 3) / 2;
    end
    return target;
  endfunction

  // Height of a column as it enters the given stage
  function automatic int columnHeight(input int stageIndex, input int col);
    int height [`PRODUCT_WIDTH];
    int carry;
    int eff;
    int target;
    for (int c = 0; c < `PRODUCT_WIDTH; c++) begin
      height[c] = (c < `OPERAND_WIDTH) ? c + 1 : 2 * `OPERAND_WIDTH - 1 - c;
    end
    for (int s = 0; s < stageIndex; s++) begin
      target = daddaTarget(s);
      carry = 0;
      for (int c = 0; c < `PRODUCT_WIDTH; c++) begin
        eff = height[c] + carry;
        if (eff > target) begin
          carry = (eff - target) / 2 + (eff - target) % 2;
          height[c] = target;
        end else begin
          carry = 0;
          height[c] = eff;
        end
      end
    end
    return height[col];
  endfunction

  function automatic addResultT halfAdd(input logic x, input logic y);
    addResultT res;
    res.sum = x ^ y;
    res.carry = x & y;
    return res;
  endfunction

  function automatic addResultT fullAdd(input logic x, input logic y, input logic cin);
    addResultT res;
    res.sum = x ^ y ^ cin;
    res.carry = (x & y) | ((x ^ y) & cin);
    return res;
  endfunction

endpackage

`default_nettype wire

// File: hdl/dadda_defines.svh
`ifndef DADDA_DEFINES_SVH
`define DADDA_DEFINES_SVH

// Operand and product widths
`define OPERAND_WIDTH 16
`define PRODUCT_WIDTH 32

// Tallest column of the initial dot matrix
`define MAX_HEIGHT 16

// Dadda stages needed to bring 16 rows down to 2
`define REDUCE_STAGES 6

// Decode, execute and result slices
`define PIPE_LATENCY 3

`endif
